// ==== flash_logger_params.svh ====
`ifndef FLASH_LOGGER_PARAMS_SVH
`define FLASH_LOGGER_PARAMS_SVH

// Command address word, wide enough for a full row address
`define FLASH_ADDR_W 24

// Buffer counts and transfer size, up to a full 4 KB page plus spare
`define FLASH_CNT_W 13

// Wait after raising the chip supply, cut down for simulation
`define FLASH_PWRUP_CYCLES 40

// Feature register addresses for GET_FEATURE and SET_FEATURE
`define FLASH_FADDR_LOCK   8'hA0
`define FLASH_FADDR_CONF   8'hB0
`define FLASH_FADDR_STATUS 8'hC0

// Expected feature contents before a page is written
`define FLASH_CONF_VALUE   8'h10 // ECC on, full drive strength
`define FLASH_UNLOCK_VALUE 8'h00 // No block protected

// Half a page is moved per round after reset
`define FLASH_XFER_RESET 13'd2048

`endif

// ==== flash_logger_pkg.sv ====
`include "flash_logger_params.svh"

package flash_logger_pkg;

  // Serial NAND opcodes as sent on the command port
  typedef enum logic [7:0] {
    NO_COMMAND    = 8'h00,
    RESET         = 8'hFF,
    GET_FEATURE   = 8'h0F,
    SET_FEATURE   = 8'h1F,
    WRITE_ENABLE  = 8'h06,
    WRITE_DISABLE = 8'h04,
    BLOCK_ERASE   = 8'hD8,
    PROG_LOAD     = 8'h02, // Loads the chip cache from column 0 onward
    PROG_EXEC     = 8'h10,
    PAGE_READ     = 8'h13,
    CACHE_READ    = 8'h03
  } flash_cmd_e;

  typedef enum logic [2:0] {
    MODE_IDLE, MODE_FILL, MODE_PWRUP, MODE_WRITE, MODE_READ, MODE_DRAIN
  } flash_mode_e;

  typedef enum logic [2:0] {
    WR_IDLE, WR_RESET, WR_CHECK, WR_CHECK_EVAL,
    WR_SET_FEATURE, WR_WRITE_ENABLE, WR_WRITE_DISABLE, WR_LOAD_EXEC
  } wr_state_e;

  typedef enum logic [2:0] {
    RD_IDLE, RD_CHECK, RD_CHECK_EVAL, RD_WRITE_DISABLE, RD_PAGE_READ, RD_CACHE_READ
  } rd_state_e;

  // The same address word carries either a feature access or a row/column address
  typedef union packed {
    struct packed {
      logic [7:0] pad;   // Not sent for feature commands
      logic [7:0] faddr; // Feature register address
      logic [7:0] fdata; // Value for SET_FEATURE
    } feat;
    logic [`FLASH_ADDR_W-1:0] row; // Page, block or column address
  } flash_addr_u;

endpackage

// ==== flash_cfg_regs.sv ====
`include "flash_logger_params.svh"

module flash_cfg_regs (
  input  logic                     CLK1,
  input  logic                     rst_n,
  input  logic                     i_cfg_wr,   // One-cycle write strobe
  input  logic                     i_cfg_sel,  // 0 writes the transfer size, 1 the page
  input  logic [`FLASH_ADDR_W-1:0] i_cfg_data,
  output logic [`FLASH_CNT_W-1:0]  o_xfer_size,
  output logic [`FLASH_ADDR_W-1:0] o_page_addr
);

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      o_xfer_size <= `FLASH_XFER_RESET;
      o_page_addr <= 24'h000345; // Clear of the OTP, parameter and unique pages
    end else if (i_cfg_wr) begin
      // Only the selected register moves, the other keeps its value
      if (i_cfg_sel) begin
        o_page_addr <= i_cfg_data;
      end else begin
        o_xfer_size <= i_cfg_data[`FLASH_CNT_W-1:0]; // Upper bits are ignored here
      end
    end
  end

endmodule

// ==== flash_mode_fsm.sv ====
`include "flash_logger_params.svh"

module flash_mode_fsm import flash_logger_pkg::*; (
  input  logic                    CLK1,
  input  logic                    rst_n,
  input  logic                    i_fill_start,
  input  logic [`FLASH_CNT_W-1:0] i_fifo_count,
  input  logic [`FLASH_CNT_W-1:0] i_xfer_size,
  input  logic                    i_drain_busy, // Buffer is still being read out
  input  logic                    i_cm_ready,
  input  logic                    i_write_done,
  input  logic                    i_read_done,
  output flash_mode_e             o_mode,
  output logic                    o_mem_vcc,    // Supply switch of the flash chip
  output logic                    o_write_start,
  output logic                    o_read_start
);

  localparam int TMR_W = $clog2(`FLASH_PWRUP_CYCLES + 1);

  logic [TMR_W-1:0] pwrup_tmr;

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      o_mode        <= MODE_IDLE;
      o_mem_vcc     <= 1'b0;
      o_write_start <= 1'b0;
      o_read_start  <= 1'b0;
      pwrup_tmr     <= '0;
    end else begin
      o_write_start <= 1'b0; // Start strobes last one cycle
      o_read_start  <= 1'b0;
      case (o_mode)
        MODE_IDLE: begin
          o_mem_vcc <= 1'b0; // Chip stays unpowered between rounds
          if (i_fill_start) o_mode <= MODE_FILL;
        end
        MODE_FILL: begin
          // Assumes the buffer was empty when filling began
          if (i_fifo_count >= i_xfer_size) o_mode <= MODE_PWRUP;
        end
        MODE_PWRUP: begin
          if (!o_mem_vcc) begin
            o_mem_vcc <= 1'b1;
            pwrup_tmr <= '0;
          end else if (pwrup_tmr == TMR_W'(`FLASH_PWRUP_CYCLES)) begin
            o_mode        <= MODE_WRITE;
            o_write_start <= 1'b1;
          end else begin
            pwrup_tmr <= pwrup_tmr + 1'b1;
          end
        end
        MODE_WRITE: begin
          if (i_write_done) begin
            o_mode       <= MODE_READ;
            o_read_start <= 1'b1; // Read back the page that was just written
          end
        end
        MODE_READ: begin
          if (i_read_done) o_mode <= MODE_DRAIN;
        end
        default: begin
          // Drain; never cut power in the middle of an SPI command
          if (i_cm_ready) o_mem_vcc <= 1'b0;
          if (i_fifo_count == '0 && !i_drain_busy) begin
            o_mode    <= MODE_IDLE;
            o_mem_vcc <= 1'b0;
          end
        end
      endcase
    end
  end

  // The sequencers talk to a powered chip only
  a_vcc_in_access: assert property (@(posedge CLK1) disable iff (!rst_n)
    (o_mode inside {MODE_WRITE, MODE_READ}) |-> o_mem_vcc);

endmodule

// ==== flash_write_seq.sv ====
`include "flash_logger_params.svh"

module flash_write_seq import flash_logger_pkg::*; (
  input  logic                     CLK1,
  input  logic                     rst_n,
  input  logic                     i_start,
  input  logic                     i_issue_ok,     // Command port can take a request now
  input  logic                     i_feature_dv,
  input  logic [7:0]               i_feature_byte,
  input  logic [`FLASH_CNT_W-1:0]  i_fifo_count,
  input  logic [`FLASH_ADDR_W-1:0] i_page_addr,
  output logic                     o_req,
  output flash_cmd_e               o_req_cmd,
  output flash_addr_u              o_req_addr,
  output logic                     o_done
);

  wr_state_e  state;
  flash_cmd_e last_cmd;    // Last command that changed the chip, GET_FEATURE excluded
  logic [7:0] feat_addr;   // Feature register targeted by the next GET/SET_FEATURE
  logic [1:0] check_twice; // Extra status polls, the first reading after a busy op is unreliable
  flash_cmd_e load_cmd;    // Next step of the erase, load, execute chain
  logic       slow_cmd;

  assign slow_cmd = last_cmd inside {RESET, BLOCK_ERASE, PROG_LOAD, PROG_EXEC};
  assign o_req    = i_issue_ok && !(state inside {WR_IDLE, WR_CHECK_EVAL});

  always_comb begin
    case (last_cmd)
      BLOCK_ERASE: load_cmd = PROG_LOAD;
      PROG_LOAD:   load_cmd = PROG_EXEC;
      default:     load_cmd = BLOCK_ERASE; // Same page every round so the block is erased first
    endcase
  end

  always_comb begin
    o_req_addr = '0;
    o_req_cmd  = NO_COMMAND;
    case (state)
      WR_RESET:         o_req_cmd = RESET;
      WR_WRITE_ENABLE:  o_req_cmd = WRITE_ENABLE;
      WR_WRITE_DISABLE: o_req_cmd = WRITE_DISABLE;
      WR_CHECK: begin
        o_req_cmd             = GET_FEATURE;
        o_req_addr.feat.faddr = feat_addr;
      end
      WR_SET_FEATURE: begin
        o_req_cmd             = SET_FEATURE;
        o_req_addr.feat.faddr = feat_addr;
        o_req_addr.feat.fdata = (feat_addr == `FLASH_FADDR_LOCK) ? `FLASH_UNLOCK_VALUE
                                                                 : `FLASH_CONF_VALUE;
      end
      WR_LOAD_EXEC: begin
        o_req_cmd = load_cmd;
        if (load_cmd == BLOCK_ERASE) begin
          o_req_addr.row = {13'b0, i_page_addr[16:6]}; // Block number, rest are dummy bits
        end else if (load_cmd == PROG_EXEC) begin
          o_req_addr.row = i_page_addr; // PROG_LOAD keeps column 0
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      state       <= WR_IDLE;
      last_cmd    <= NO_COMMAND;
      feat_addr   <= `FLASH_FADDR_STATUS;
      check_twice <= '0;
      o_done      <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (state == WR_IDLE) begin
        if (i_start) state <= WR_RESET; // Every write begins with a chip reset
      end else if (state == WR_CHECK_EVAL) begin
        if (i_feature_dv) begin
          state <= WR_CHECK; // Poll again unless a rule below decides otherwise
          if (feat_addr == `FLASH_FADDR_LOCK) begin
            if (i_feature_byte != `FLASH_UNLOCK_VALUE) state <= WR_SET_FEATURE;
            else feat_addr <= `FLASH_FADDR_CONF;
          end else if (feat_addr == `FLASH_FADDR_CONF) begin
            if (i_feature_byte != `FLASH_CONF_VALUE) state <= WR_SET_FEATURE;
            else feat_addr <= `FLASH_FADDR_STATUS;
          end else if (check_twice == 2'd0 && slow_cmd) begin
            check_twice <= 2'd1;
          end else if (check_twice == 2'd1 && last_cmd == RESET) begin
            check_twice <= 2'd2; // Reset gets a third poll
          end else if (i_feature_byte[0]) begin
            state <= WR_CHECK; // Operation in progress
          end else if (i_feature_byte[3] || i_feature_byte[2]) begin
            state <= WR_RESET; // Program or erase fail, reset clears the flags
          end else if (last_cmd == RESET) begin
            feat_addr <= `FLASH_FADDR_LOCK; // Chip is idle after reset, set up features
            last_cmd  <= GET_FEATURE;
          end else if (last_cmd == WRITE_DISABLE && !i_feature_byte[1] && i_fifo_count == '0) begin
            state  <= WR_IDLE;
            o_done <= 1'b1;
          end else if ((last_cmd == WRITE_DISABLE && i_feature_byte[1]) ||
                       last_cmd == PROG_EXEC) begin
            state <= WR_WRITE_DISABLE;
          end else if (!i_feature_byte[1]) begin
            state <= WR_WRITE_ENABLE; // Write enable latch must be set before erase or load
          end else begin
            state <= WR_LOAD_EXEC;
          end
        end
      end else if (o_req) begin
        state <= (state == WR_CHECK) ? WR_CHECK_EVAL : WR_CHECK;
        // WRITE_ENABLE is left out so the chain resumes where it stopped
        if (!(state inside {WR_CHECK, WR_WRITE_ENABLE})) last_cmd <= o_req_cmd;
        if (state inside {WR_RESET, WR_LOAD_EXEC}) check_twice <= '0;
        if (state == WR_RESET) feat_addr <= `FLASH_FADDR_STATUS;
      end
    end
  end

endmodule

// ==== flash_read_seq.sv ====
`include "flash_logger_params.svh"

module flash_read_seq import flash_logger_pkg::*; (
  input  logic                     CLK1,
  input  logic                     rst_n,
  input  logic                     i_start,
  input  logic                     i_issue_ok,
  input  logic                     i_feature_dv,
  input  logic [7:0]               i_feature_byte, // Status byte from GET_FEATURE
  input  logic [`FLASH_CNT_W-1:0]  i_fifo_count,
  input  logic [`FLASH_CNT_W-1:0]  i_xfer_size,
  input  logic [`FLASH_ADDR_W-1:0] i_page_addr,
  output logic                     o_req,
  output flash_cmd_e               o_req_cmd,
  output flash_addr_u              o_req_addr,
  output logic                     o_done
);

  rd_state_e  state;
  flash_cmd_e last_cmd;
  logic       polled_once; // Status after a read is polled at least twice
  logic       after_read;

  assign after_read = last_cmd inside {PAGE_READ, CACHE_READ};
  assign o_req      = i_issue_ok && !(state inside {RD_IDLE, RD_CHECK_EVAL});

  always_comb begin
    o_req_addr = '0; // CACHE_READ starts at column 0
    case (state)
      RD_CHECK: begin
        o_req_cmd             = GET_FEATURE;
        o_req_addr.feat.faddr = `FLASH_FADDR_STATUS;
      end
      RD_WRITE_DISABLE: o_req_cmd = WRITE_DISABLE;
      RD_PAGE_READ: begin
        o_req_cmd      = PAGE_READ; // Moves the page into the chip cache
        o_req_addr.row = i_page_addr;
      end
      RD_CACHE_READ: o_req_cmd = CACHE_READ;
      default:       o_req_cmd = NO_COMMAND;
    endcase
  end

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      state       <= RD_IDLE;
      last_cmd    <= NO_COMMAND;
      polled_once <= 1'b0;
      o_done      <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (state == RD_IDLE) begin
        if (i_start) state <= RD_CHECK;
        last_cmd <= NO_COMMAND;
      end else if (state == RD_CHECK_EVAL) begin
        if (i_feature_dv) begin
          state <= RD_CHECK;
          if (!polled_once && after_read) polled_once <= 1'b1;
          else if (i_feature_byte[0] || i_feature_byte[7]) state <= RD_CHECK; // OIP or cache busy
          else if (i_feature_byte[1]) state <= RD_WRITE_DISABLE;
          else if (!after_read) state <= RD_PAGE_READ;
          else if (last_cmd == PAGE_READ) state <= RD_CACHE_READ;
          else if (i_fifo_count >= i_xfer_size) begin
            state  <= RD_IDLE; // Whole transfer is back in the buffer
            o_done <= 1'b1;
          end
        end
      end else if (o_req) begin
        state <= (state == RD_CHECK) ? RD_CHECK_EVAL : RD_CHECK;
        if (state != RD_CHECK) begin
          last_cmd    <= o_req_cmd;
          polled_once <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== flash_cmd_issue.sv ====
`include "flash_logger_params.svh"

module flash_cmd_issue import flash_logger_pkg::*; (
  input  logic                     CLK1,
  input  logic                     rst_n,
  input  logic                     i_cm_ready,  // Engine idle and able to take a command
  input  logic                     i_wr_req,
  input  flash_cmd_e               i_wr_cmd,
  input  flash_addr_u              i_wr_addr,
  input  logic                     i_rd_req,
  input  flash_cmd_e               i_rd_cmd,
  input  flash_addr_u              i_rd_addr,
  output logic                     o_issue_ok,
  output flash_cmd_e               o_cmd,
  output logic [`FLASH_ADDR_W-1:0] o_addr_data,
  output logic                     o_cm_dv
);

  logic take;

  // Ready may still be high the cycle after a pulse, so that cycle is skipped
  assign o_issue_ok = i_cm_ready && !o_cm_dv;
  assign take       = (i_wr_req || i_rd_req) && o_issue_ok;

  always_ff @(posedge CLK1 or negedge rst_n) begin
    if (!rst_n) begin
      o_cm_dv <= 1'b0;
      o_cmd   <= NO_COMMAND;
    end else begin
      o_cm_dv <= take;
      if (take) o_cmd <= i_wr_req ? i_wr_cmd : i_rd_cmd; // Held until the next pulse
    end
  end

  always_ff @(posedge CLK1) begin
    if (take) o_addr_data <= i_wr_req ? i_wr_addr.row : i_rd_addr.row;
  end

  // Only the sequencer of the current mode may be active
  a_one_req: assert property (@(posedge CLK1) disable iff (!rst_n) !(i_wr_req && i_rd_req));

  // The engine takes ready away in the cycle after it accepted a command
  a_ready_drop: assert property (@(posedge CLK1) disable iff (!rst_n) o_cm_dv |=> !i_cm_ready);

endmodule

// ==== flash_logger_top.sv ====
`include "flash_logger_params.svh"

module flash_logger_top import flash_logger_pkg::*; (
  input  logic                     CLK1,
  input  logic                     rst_n,
  input  logic                     i_fill_start,
  input  logic [`FLASH_CNT_W-1:0]  i_fifo_count,
  input  logic                     i_drain_busy,
  input  logic                     i_cfg_wr,
  input  logic                     i_cfg_sel,
  input  logic [`FLASH_ADDR_W-1:0] i_cfg_data,
  input  logic                     i_cm_ready,
  input  logic                     i_feature_dv,
  input  logic [7:0]               i_feature_byte,
  output flash_mode_e              o_mode,
  output logic                     o_mem_vcc,
  output flash_cmd_e               o_cmd,
  output logic [`FLASH_ADDR_W-1:0] o_addr_data,
  output logic                     o_cm_dv
);

  logic [`FLASH_CNT_W-1:0]  xfer_size;
  logic [`FLASH_ADDR_W-1:0] page_addr;
  logic                     write_start, write_done, read_start, read_done;
  logic                     issue_ok, wr_req, rd_req;
  flash_cmd_e               wr_cmd, rd_cmd;
  flash_addr_u              wr_addr, rd_addr;

  flash_cfg_regs u_cfg (.CLK1, .rst_n, .i_cfg_wr, .i_cfg_sel, .i_cfg_data,
    .o_xfer_size(xfer_size), .o_page_addr(page_addr));

  flash_mode_fsm u_mode (.CLK1, .rst_n, .i_fill_start, .i_fifo_count, .i_xfer_size(xfer_size),
    .i_drain_busy, .i_cm_ready, .i_write_done(write_done), .i_read_done(read_done),
    .o_mode, .o_mem_vcc, .o_write_start(write_start), .o_read_start(read_start));

  flash_write_seq u_wr (.CLK1, .rst_n, .i_start(write_start), .i_issue_ok(issue_ok),
    .i_feature_dv, .i_feature_byte, .i_fifo_count, .i_page_addr(page_addr),
    .o_req(wr_req), .o_req_cmd(wr_cmd), .o_req_addr(wr_addr), .o_done(write_done));

  flash_read_seq u_rd (.CLK1, .rst_n, .i_start(read_start), .i_issue_ok(issue_ok),
    .i_feature_dv, .i_feature_byte, .i_fifo_count, .i_xfer_size(xfer_size),
    .i_page_addr(page_addr), .o_req(rd_req), .o_req_cmd(rd_cmd), .o_req_addr(rd_addr),
    .o_done(read_done));

  // Single point where commands reach the SPI engine
  flash_cmd_issue u_issue (.CLK1, .rst_n, .i_cm_ready, .i_wr_req(wr_req), .i_wr_cmd(wr_cmd),
    .i_wr_addr(wr_addr), .i_rd_req(rd_req), .i_rd_cmd(rd_cmd), .i_rd_addr(rd_addr),
    .o_issue_ok(issue_ok), .o_cmd, .o_addr_data, .o_cm_dv);

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int HALF_PERIOD  = 4,  // 8 unit clock
  parameter int RESET_CYCLES = 10
) (
  output logic CLK1,
  output logic rst_n
);

  initial begin
    CLK1 = 1'b0;
    forever #HALF_PERIOD CLK1 = ~CLK1;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK1);
    rst_n <= 1'b1; // Released on an edge like every other input
  end

endmodule

// ==== tb_flash_logger.sv ====
`include "flash_logger_params.svh"

module tb_flash_logger import flash_logger_pkg::*; ();

  localparam logic [`FLASH_CNT_W-1:0] XFER = 13'd16;
  localparam int ROUND_CYCLES = 600;
  localparam int LIMIT        = 2 * ROUND_CYCLES + 200; // Two rounds plus margin
  localparam int PW           = `FLASH_PWRUP_CYCLES;

  logic CLK1, rst_n;
  logic i_fill_start, i_drain_busy, i_cfg_wr, i_cfg_sel, i_cm_ready, i_feature_dv;
  logic [`FLASH_CNT_W-1:0]  i_fifo_count;
  logic [`FLASH_ADDR_W-1:0] i_cfg_data, o_addr_data;
  logic [7:0]               i_feature_byte;
  flash_mode_e              o_mode;
  flash_cmd_e               o_cmd;
  logic                     o_mem_vcc, o_cm_dv;

  // Chip model state
  logic [7:0] lock_byte, conf_byte;
  logic       wel;
  logic [1:0] busy_polls; // Status polls left that still report busy
  logic [2:0] wait_cnt;
  integer     seed;
  int         cycles;
  int         errs [1:6];
  int         cur_round;
  logic       fill_seen;
  flash_cmd_e exp_cmd [0:15];
  logic [23:0] exp_addr [0:15];
  logic [3:0] exp_idx;

  tb_clock_gen u_clk (.CLK1(CLK1), .rst_n(rst_n));

  flash_logger_top uut (.CLK1, .rst_n, .i_fill_start, .i_fifo_count, .i_drain_busy, .i_cfg_wr,
    .i_cfg_sel, .i_cfg_data, .i_cm_ready, .i_feature_dv, .i_feature_byte, .o_mode, .o_mem_vcc,
    .o_cmd, .o_addr_data, .o_cm_dv);

  task automatic fail_value(input int t, input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    $display("ERROR test %0d %s expected %0h actual %0h", t, name, exp, act);
    errs[t]++;
  endtask

  task automatic fail_note(input int t, input string msg);
    $display("Check of test %0d failed, %s", t, msg);
    errs[t]++;
  endtask

  task automatic report_test(input int t, input string name);
    $display("test %0d %s round %0d: %s", t, name, cur_round, (errs[t] == 0) ? "ok" : "failed");
  endtask

  // Command list of one round with the write phase ahead of the read phase
  task automatic build_expected(input logic [23:0] page);
    foreach (exp_cmd[i]) begin
      exp_cmd[i]  = NO_COMMAND;
      exp_addr[i] = 24'h0;
    end
    exp_cmd[0] = RESET;
    exp_cmd[1] = SET_FEATURE;
    exp_addr[1] = {8'h00, 8'hA0, 8'h00};
    exp_cmd[2] = SET_FEATURE;
    exp_addr[2] = {8'h00, 8'hB0, 8'h10};
    exp_cmd[3] = WRITE_ENABLE;
    exp_cmd[4] = BLOCK_ERASE;
    exp_addr[4] = {13'b0, page[16:6]};
    exp_cmd[5] = PROG_LOAD;
    exp_cmd[6] = PROG_EXEC;
    exp_addr[6] = page;
    exp_cmd[7] = WRITE_DISABLE;
    exp_cmd[8] = PAGE_READ;
    exp_addr[8] = page;
    exp_cmd[9] = CACHE_READ;
  endtask

  task automatic write_cfg(input logic sel, input logic [23:0] data);
    @(posedge CLK1);
    i_cfg_wr   <= 1'b1;
    i_cfg_sel  <= sel;
    i_cfg_data <= data;
    @(posedge CLK1);
    i_cfg_wr   <= 1'b0;
  endtask

  task automatic wait_mode(input flash_mode_e m);
    do @(negedge CLK1); while (o_mode != m); // Outputs are settled at the falling edge
  endtask

  // Engine, chip and buffer at command level
  always @(posedge CLK1) begin
    i_feature_dv <= 1'b0;
    if (!o_mem_vcc) begin
      lock_byte <= 8'h38; // Power cycle restores the protected default
      conf_byte <= 8'h00;
    end
    if (o_mode == MODE_FILL && i_fifo_count < XFER) i_fifo_count <= i_fifo_count + 1'b1;
    if (o_mode == MODE_DRAIN && i_fifo_count != '0) i_fifo_count <= i_fifo_count - 1'b1;
    i_drain_busy <= (o_mode == MODE_DRAIN) && (i_fifo_count > 13'd1);
    if (o_cm_dv) begin
      i_cm_ready <= 1'b0;
      wait_cnt   <= 3'(1 + $unsigned($random(seed)) % 5);
      case (o_cmd)
        RESET, BLOCK_ERASE, PROG_EXEC, PAGE_READ: busy_polls <= 2'd2;
        WRITE_ENABLE:  wel <= 1'b1;
        WRITE_DISABLE: wel <= 1'b0;
        PROG_LOAD:     i_fifo_count <= '0;
        CACHE_READ:    i_fifo_count <= XFER;
        SET_FEATURE: begin
          if (o_addr_data[15:8] == 8'hA0) lock_byte <= o_addr_data[7:0];
          if (o_addr_data[15:8] == 8'hB0) conf_byte <= o_addr_data[7:0];
        end
        GET_FEATURE: begin
          i_feature_dv <= 1'b1; // Byte returns before ready comes back
          case (o_addr_data[15:8])
            8'hA0:   i_feature_byte <= lock_byte;
            8'hB0:   i_feature_byte <= conf_byte;
            default: begin
              i_feature_byte <= {6'b0, wel, busy_polls != 2'd0};
              if (busy_polls != 2'd0) busy_polls <= busy_polls - 1'b1;
            end
          endcase
        end
        default: ;
      endcase
    end else if (!i_cm_ready) begin
      if (wait_cnt <= 3'd1) i_cm_ready <= 1'b1;
      else wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // Position in the expected command list
  always @(posedge CLK1) begin
    if (o_mode == MODE_FILL) exp_idx <= '0;
    else if (o_cm_dv && o_cmd != GET_FEATURE) exp_idx <= exp_idx + 1'b1;
  end

  always @(posedge CLK1) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, mode %s never returned to idle", cycles, o_mode.name());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Mode, supply, pulse and command are packed into one word for the error line
  a_reset_idle: assert property (@(posedge CLK1) disable iff (!rst_n)
    !fill_seen |-> (o_mode == MODE_IDLE && !o_mem_vcc && !o_cm_dv && o_cmd == NO_COMMAND))
    else fail_value(1, "reset_idle", {19'b0, MODE_IDLE, 2'b00, NO_COMMAND},
                    {19'b0, $sampled(o_mode), $sampled(o_mem_vcc), $sampled(o_cm_dv),
                     $sampled(o_cmd)});

  a_fill_entry: assert property (@(posedge CLK1) disable iff (!rst_n)
    (o_mode == MODE_IDLE && i_fill_start) |=> o_mode == MODE_FILL)
    else fail_value(2, "fill_entry", {29'b0, MODE_FILL}, {29'b0, $sampled(o_mode)});
  a_pwrup_entry: assert property (@(posedge CLK1) disable iff (!rst_n)
    (o_mode == MODE_FILL && i_fifo_count >= XFER) |=> o_mode == MODE_PWRUP)
    else fail_value(2, "pwrup_entry", {29'b0, MODE_PWRUP}, {29'b0, $sampled(o_mode)});
  a_vcc_rise: assert property (@(posedge CLK1) disable iff (!rst_n)
    $rose(o_mode == MODE_PWRUP) |-> (!o_mem_vcc ##1 o_mem_vcc))
    else fail_note(2, "supply did not rise one cycle after power-up began");
  // Write begins exactly PW+1 cycles after the supply came up
  a_pwrup_time: assert property (@(posedge CLK1) disable iff (!rst_n)
    (o_mode == MODE_WRITE && $past(o_mode) == MODE_PWRUP) |->
      ($past(o_mem_vcc, PW + 1) && !$past(o_mem_vcc, PW + 2)))
    else fail_note(2, "write mode did not start at the end of the power-up time");

  a_cmd_order: assert property (@(posedge CLK1) disable iff (!rst_n)
    (o_cm_dv && o_cmd != GET_FEATURE) |->
      (o_cmd == exp_cmd[exp_idx] && o_addr_data == exp_addr[exp_idx]))
    else fail_value((cur_round != 0) ? 6 : ($sampled(exp_idx) < 4'd8) ? 3 : 4, "cmd_order",
                    {exp_cmd[$sampled(exp_idx)], exp_addr[$sampled(exp_idx)]},
                    {$sampled(o_cmd), $sampled(o_addr_data)});

  a_drain_entry: assert property (@(posedge CLK1) disable iff (!rst_n)
    $rose(o_mode == MODE_DRAIN) |-> exp_idx == 4'd10)
    else fail_value(4, "drain_entry", 10, {28'b0, $sampled(exp_idx)});

  a_dv_ready: assert property (@(posedge CLK1) disable iff (!rst_n)
    o_cm_dv |-> (i_cm_ready && !$past(o_cm_dv)))
    else fail_note(5, "command pulse without ready or right after another pulse");

  a_idle_off: assert property (@(posedge CLK1) disable iff (!rst_n)
    $rose(o_mode == MODE_IDLE) |-> !o_mem_vcc)
    else fail_value(6, "idle_vcc", 0, {31'b0, $sampled(o_mem_vcc)});

  initial begin
    int total;
    seed = 34;
    cycles = 0;
    cur_round = 0;
    fill_seen = 1'b0;
    foreach (errs[i]) errs[i] = 0;
    i_fill_start = 1'b0;
    i_fifo_count = '0;
    i_drain_busy = 1'b0;
    i_cfg_wr = 1'b0;
    i_cfg_sel = 1'b0;
    i_cfg_data = '0;
    i_cm_ready = 1'b1;
    i_feature_dv = 1'b0;
    i_feature_byte = 8'h00;
    lock_byte = 8'h38;
    conf_byte = 8'h00;
    wel = 1'b0;
    busy_polls = 2'd0;
    wait_cnt = 3'd0;
    exp_idx = '0;
    build_expected(24'h000345);
    wait (rst_n);
    write_cfg(1'b0, {11'b0, XFER});
    repeat (4) @(posedge CLK1);
    report_test(1, "reset state");
    for (int r = 0; r < 2; r++) begin
      cur_round = r;
      if (r == 1) begin
        write_cfg(1'b1, 24'h0001C0); // Second round moves to another block
        build_expected(24'h0001C0);
      end
      @(posedge CLK1);
      i_fill_start <= 1'b1;
      fill_seen    <= 1'b1;
      @(posedge CLK1);
      i_fill_start <= 1'b0;
      wait_mode(MODE_WRITE);
      report_test(2, "fill and power-up");
      wait_mode(MODE_READ);
      if (exp_idx != 4'd8) fail_note(3, "write phase ended before its last command");
      report_test(3, "write commands");
      wait_mode(MODE_DRAIN);
      report_test(4, "read commands");
      wait_mode(MODE_IDLE);
      report_test(5, "command handshake");
    end
    report_test(6, "drain and second page");
    total = 0;
    foreach (errs[i]) total += errs[i];
    $display("tests run 6, rounds 2, failed checks %0d, cycles %0d", total, cycles);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== flash_logger.f ====
+incdir+.
flash_logger_pkg.sv
flash_cfg_regs.sv
flash_mode_fsm.sv
flash_write_seq.sv
flash_read_seq.sv
flash_cmd_issue.sv
flash_logger_top.sv
tb_clock_gen.sv
tb_flash_logger.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -f flash_logger.f --top-module tb_flash_logger \
  -o sim_flash_logger > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_flash_logger > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log && exit 0 || exit 1
